//--- filelist.f
design/cache_pkg.sv
design/lfsr_8bit.sv
design/tag_array.sv
design/data_array.sv
design/cache.sv
design/main_mem_ctrl.sv
design/cache_subsystem.sv
verification/cache_subsystem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, and decide by the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module cache_subsystem_tb \
    -f filelist.f -o cache_subsystem_tb || exit 1
out="$(./obj_dir/cache_subsystem_tb)"
echo "$out"
echo "$out" | grep -q "^TESTBENCH PASSED$" && exit 0 || exit 1

//--- verification/cache_subsystem_tb.sv
`timescale 1ns/1ps

module cache_subsystem_tb
    import cache_pkg::*;
();
    localparam int REQ_LIMIT = 40;    // a refill with replay takes about 10 cycles
    localparam int RUN_LIMIT = 4000;  // about 200 requests at worst-case miss, plus margin

    logic       clk = 1'b0;
    logic       rst_aL;
    logic       init;
    logic       req_valid;
    req_type_t  req_type;
    req_width_t req_width;
    addr_t      req_addr;
    word_t      req_wr_data;
    logic       resp_valid;
    word_t      resp_rd_data;

    logic [7:0] ref_mem [2048];    // byte-wide reference of the low 2 KB
    bit         ref_known [2048];  // byte has been stored at least once
    integer     seed = 78;
    int         err_count = 0;
    int         tests_passed = 0;
    int         tests_failed = 0;
    int         cycle_count = 0;
    int         last_latency;
    word_t      last_rd_data;

    cache_subsystem #(
        .N_SETS      (16),
        .MEM_BLOCKS  (256),
        .MEM_LATENCY (3)
    ) cache_subsystem_i (
        .clk          (clk),
        .rst_aL       (rst_aL),
        .init         (init),
        .req_valid    (req_valid),
        .req_type     (req_type),
        .req_width    (req_width),
        .req_addr     (req_addr),
        .req_wr_data  (req_wr_data),
        .resp_valid   (resp_valid),
        .resp_rd_data (resp_rd_data)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count == RUN_LIMIT) begin
            $display("Run stopped after %0d cycles without finishing the tests", RUN_LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // present one request on the falling edge and hold it until resp_valid
    task automatic run_request(input req_type_t kind, input req_width_t width,
                               input addr_t addr, input word_t data);
        int n;
        n = 0;
        req_valid = 1'b1;
        req_type = kind;
        req_width = width;
        req_addr = addr;
        req_wr_data = data;
        do begin
            @(negedge clk);
            n++;
        end while (!resp_valid && n < REQ_LIMIT);
        if (!resp_valid) begin
            $display("Request to address %h got no response within %0d cycles", addr, REQ_LIMIT);
            err_count++;
        end
        last_latency = n;
        last_rd_data = resp_rd_data;
        req_valid = 1'b0;
        @(negedge clk);  // idle cycle so the next request starts clean
    endtask

    task automatic do_store(input addr_t addr, input req_width_t width, input word_t data);
        int nbytes;
        nbytes = (width == BYTE) ? 1 : (width == HALFWORD) ? 2 : 4;
        for (int i = 0; i < nbytes; i++) begin
            ref_mem[addr[10:0] + i] = data[8*i +: 8];  // little-endian lanes
            ref_known[addr[10:0] + i] = 1'b1;
        end
        run_request(WRITE, width, addr, data);
    endtask

    // only bytes stored before are compared, memory starts undefined
    task automatic do_read(input addr_t addr);
        addr_t base;
        word_t exp_word;
        word_t mask;
        base = {addr[15:2], 2'b00};
        for (int i = 0; i < 4; i++) begin
            exp_word[8*i +: 8] = ref_mem[base[10:0] + i];
            mask[8*i +: 8] = ref_known[base[10:0] + i] ? 8'hff : 8'h00;
        end
        run_request(READ, WORD, base, '0);
        if ((last_rd_data & mask) !== (exp_word & mask)) begin
            $display("Fail at %0t: resp_rd_data at %h expected %h got %h (mask %h)",
                     $time, base, exp_word & mask, last_rd_data & mask, mask);
            err_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("%s: passed", name);
            tests_passed++;
        end else begin
            $display("%s: failed with %0d errors", name, err_count - errs_before);
            tests_failed++;
        end
    endtask

    task automatic test_idle_after_reset();
        int errs;
        errs = err_count;
        repeat (8) begin
            @(negedge clk);
            if (resp_valid !== 1'b0) begin
                $display("Fail at %0t: resp_valid expected 0 got %b", $time, resp_valid);
                err_count++;
            end
        end
        report_test("idle after reset", errs);
    endtask

    // store miss, read back, then a hit read that must answer in two cycles
    task automatic check_roundtrip(input addr_t base, input word_t data);
        do_store(base, WORD, data);
        do_read(base);
        do_read(base);
        if (last_latency != 2) begin
            $display("Fail at %0t: resp_valid latency expected 2 got %0d", $time, last_latency);
            err_count++;
        end
    endtask

    task automatic test_store_miss_read();
        int errs;
        errs = err_count;
        check_roundtrip(16'h0600, 32'h1234_5678);
        report_test("store miss then read", errs);
    endtask

    task automatic test_byte_merge();
        int errs;
        errs = err_count;
        do_store(16'h0640, WORD, 32'ha5a5_a5a5);
        do_store(16'h0644, WORD, 32'h5a5a_5a5a);
        for (int off = 0; off < 8; off += 2) begin
            do_store(16'h0640 + off, HALFWORD, $random(seed));
            do_read(16'h0640);
            do_read(16'h0644);
        end
        for (int off = 0; off < 8; off++) begin
            do_store(16'h0640 + off, BYTE, $random(seed));
            do_read(16'h0640 + off);
        end
        report_test("byte and halfword merge", errs);
    endtask

    // index 1 for all three, tags differ so one block gets evicted
    task automatic test_eviction();
        int errs;
        errs = err_count;
        do_store(16'h0408, WORD, 32'h0bad_f00d);
        do_store(16'h0488, WORD, 32'h1357_9bdf);
        do_store(16'h0508, WORD, 32'h2468_ace0);
        do_read(16'h0408);
        do_read(16'h0488);
        do_read(16'h0508);
        do_read(16'h0408);
        report_test("same-set eviction", errs);
    endtask

    task automatic test_random_mix();
        int errs;
        integer r;
        addr_t addr;
        req_width_t width;
        errs = err_count;
        for (int k = 0; k < 150; k++) begin
            r = $random(seed);
            addr = {7'd0, r[8:0]};  // 64 blocks
            case (r[10:9])
                2'd0: width = BYTE;
                2'd1: width = HALFWORD;
                default: width = WORD;
            endcase
            if (width == HALFWORD) addr[0] = 1'b0;
            if (width == WORD) addr[1:0] = 2'b00;
            if (r[11]) begin
                do_store(addr, width, $random(seed));
            end else begin
                do_read(addr);
            end
        end
        report_test("random mix", errs);
    endtask

    task automatic test_after_init();
        int errs;
        errs = err_count;
        init = 1'b1;
        @(negedge clk);
        init = 1'b0;
        @(negedge clk);
        check_roundtrip(16'h0700, 32'hc0ff_ee01);
        report_test("roundtrip after init", errs);
    endtask

    initial begin
        rst_aL = 1'b0;
        init = 1'b0;
        req_valid = 1'b0;
        req_type = READ;
        req_width = WORD;
        req_addr = '0;
        req_wr_data = '0;
        repeat (16) @(negedge clk);
        rst_aL = 1'b1;

        test_idle_after_reset();
        test_store_miss_read();
        test_byte_merge();
        test_eviction();
        test_random_mix();
        test_after_init();

        $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && err_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- design/cache_subsystem.sv
`timescale 1ns/1ps

module cache_subsystem
    import cache_pkg::*;
#(
    parameter int unsigned N_SETS = 16,
    parameter int unsigned MEM_BLOCKS = 256,
    parameter int unsigned MEM_LATENCY = 3
) (
    input  logic       clk,
    input  logic       rst_aL,
    input  logic       init,
    input  logic       req_valid,
    input  req_type_t  req_type,
    input  req_width_t req_width,
    input  addr_t      req_addr,
    input  word_t      req_wr_data,
    output logic       resp_valid,
    output word_t      resp_rd_data
);
    // cache to memory controller
    logic        mem_req_valid;
    req_type_t   mem_req_type;
    block_addr_t mem_req_block_addr;
    block_data_t mem_req_block_data;
    logic        mem_req_ready;
    logic        mem_resp_valid;
    block_data_t mem_resp_block_data;

    cache #(.N_SETS(N_SETS)) cache_i (
        .clk                 (clk),
        .rst_aL              (rst_aL),
        .init                (init),
        .req_valid           (req_valid),
        .req_type            (req_type),
        .req_width           (req_width),
        .req_addr            (req_addr),
        .req_wr_data         (req_wr_data),
        .resp_valid          (resp_valid),
        .resp_rd_data        (resp_rd_data),
        .mem_req_valid       (mem_req_valid),
        .mem_req_type        (mem_req_type),
        .mem_req_block_addr  (mem_req_block_addr),
        .mem_req_block_data  (mem_req_block_data),
        .mem_req_ready       (mem_req_ready),
        .mem_resp_valid      (mem_resp_valid),
        .mem_resp_block_data (mem_resp_block_data)
    );

    main_mem_ctrl #(
        .MEM_BLOCKS  (MEM_BLOCKS),
        .MEM_LATENCY (MEM_LATENCY)
    ) main_mem_ctrl_i (
        .clk                 (clk),
        .rst_aL              (rst_aL),
        .mem_req_valid       (mem_req_valid),
        .mem_req_type        (mem_req_type),
        .mem_req_block_addr  (mem_req_block_addr),
        .mem_req_block_data  (mem_req_block_data),
        .mem_req_ready       (mem_req_ready),
        .mem_resp_valid      (mem_resp_valid),
        .mem_resp_block_data (mem_resp_block_data)
    );

endmodule

//--- design/main_mem_ctrl.sv
`timescale 1ns/1ps

module main_mem_ctrl
    import cache_pkg::*;
#(
    parameter int unsigned MEM_BLOCKS = 256,
    parameter int unsigned MEM_LATENCY = 3,
    localparam int unsigned MEM_INDEX_BITS = $clog2(MEM_BLOCKS),
    localparam int unsigned CNT_BITS = $clog2(MEM_LATENCY + 1)
) (
    input  logic        clk,
    input  logic        rst_aL,
    input  logic        mem_req_valid,
    input  req_type_t   mem_req_type,
    input  block_addr_t mem_req_block_addr,
    input  block_data_t mem_req_block_data,
    output logic        mem_req_ready,
    output logic        mem_resp_valid,
    output block_data_t mem_resp_block_data
);
    block_data_t mem [MEM_BLOCKS];

    logic                      pending;   // read accepted, response not yet sent
    logic [CNT_BITS-1:0]       cnt;
    logic                      xfer, rd_xfer;
    logic [MEM_INDEX_BITS-1:0] mem_index;

    assign xfer = mem_req_valid & mem_req_ready;
    assign rd_xfer = xfer & (mem_req_type == READ);
    assign mem_index = mem_req_block_addr[MEM_INDEX_BITS-1:0];
    assign mem_resp_valid = pending & (cnt == '0);
    assign mem_req_ready = ~pending | mem_resp_valid;  // free again in the response cycle

    always_ff @(posedge clk) begin
        if (!rst_aL) begin
            pending <= 1'b0;
            cnt <= '0;
        end else if (rd_xfer) begin
            pending <= 1'b1;
            cnt <= CNT_BITS'(MEM_LATENCY - 1);
        end else if (mem_resp_valid) begin
            pending <= 1'b0;
        end else if (pending) begin
            cnt <= cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer && mem_req_type == WRITE) mem[mem_index] <= mem_req_block_data;
        if (rd_xfer) mem_resp_block_data <= mem[mem_index];
    end

    a_read_latency: assert property (@(posedge clk) disable iff (!rst_aL)
        rd_xfer |-> ##MEM_LATENCY mem_resp_valid);

    // requester keeps only one read outstanding
    a_no_req_while_pending: assert property (@(posedge clk) disable iff (!rst_aL)
        (pending && !mem_resp_valid) |-> !mem_req_valid);

endmodule

//--- design/cache.sv
`timescale 1ns/1ps

module cache
    import cache_pkg::*;
#(
    parameter int unsigned N_SETS = 16,
    localparam int unsigned N_INDEX_BITS = $clog2(N_SETS),
    localparam int unsigned N_TAG_BITS = ADDR_WIDTH - N_OFFSET_BITS - N_INDEX_BITS
) (
    input  logic        clk,
    input  logic        rst_aL,
    input  logic        init,
    input  logic        req_valid,
    input  req_type_t   req_type,
    input  req_width_t  req_width,
    input  addr_t       req_addr,
    input  word_t       req_wr_data,
    output logic        resp_valid,
    output word_t       resp_rd_data,
    output logic        mem_req_valid,
    output req_type_t   mem_req_type,
    output block_addr_t mem_req_block_addr,
    output block_data_t mem_req_block_data,
    input  logic        mem_req_ready,
    input  logic        mem_resp_valid,
    input  block_data_t mem_resp_block_data
);
    localparam logic [2:0] IDLE        = 3'd0;
    localparam logic [2:0] COMPARE     = 3'd1;
    localparam logic [2:0] REFILL_REQ  = 3'd2;
    localparam logic [2:0] REFILL_WAIT = 3'd3;
    localparam logic [2:0] WRITE_REQ   = 3'd4;

    logic [2:0] state;

    req_type_t   type_q;
    req_width_t  width_q;
    addr_t       addr_q;
    word_t       wr_data_q;
    logic        victim;      // way picked for the refill

    logic                    random_way;
    logic                    way0_valid, way1_valid;
    logic [N_TAG_BITS-1:0]   way0_tag, way1_tag;
    block_data_t             rd_block0, rd_block1;
    logic [N_INDEX_BITS-1:0] arr_index;
    logic                    accept, store_wr, refill_wr;
    logic                    sel0, sel1, hit, victim_next;
    logic [7:0]              store_mask;
    block_data_t             store_block, hit_block, merged_block, arr_wr_block;

    // lookup stage splits the address straight from the request port
    assign accept = (state == IDLE) & req_valid & ~resp_valid;
    assign arr_index = (state == IDLE) ? req_addr[N_OFFSET_BITS +: N_INDEX_BITS]
                                       : addr_q[N_OFFSET_BITS +: N_INDEX_BITS];

    // compare stage
    assign sel0 = way0_valid & (way0_tag == addr_q[ADDR_WIDTH-1 -: N_TAG_BITS]);
    assign sel1 = way1_valid & (way1_tag == addr_q[ADDR_WIDTH-1 -: N_TAG_BITS]);
    assign hit = sel0 | sel1;
    assign hit_block = sel1 ? rd_block1 : rd_block0;
    assign victim_next = ~way0_valid ? 1'b0 :
                         ~way1_valid ? 1'b1 : random_way;

    assign store_wr = (state == COMPARE) & hit & (type_q == WRITE);
    assign refill_wr = (state == REFILL_WAIT) & mem_resp_valid;

    always_comb begin
        case (width_q)
            BYTE: begin
                store_mask = 8'h01 << addr_q[N_OFFSET_BITS-1:0];
                store_block = {8{wr_data_q[7:0]}};
            end
            HALFWORD: begin
                store_mask = 8'h03 << addr_q[N_OFFSET_BITS-1:0];
                store_block = {4{wr_data_q[15:0]}};
            end
            default: begin
                store_mask = 8'h0f << addr_q[N_OFFSET_BITS-1:0];
                store_block = {2{wr_data_q}};
            end
        endcase
    end

    always_comb begin
        for (int b = 0; b < 8; b++) begin
            merged_block[8*b +: 8] = store_mask[b] ? store_block[8*b +: 8] : hit_block[8*b +: 8];
        end
    end

    assign arr_wr_block = refill_wr ? mem_resp_block_data : store_block;

    lfsr_8bit lfsr_i (
        .clk     (clk),
        .rst_aL  (rst_aL),
        .init    (init),
        .out_bit (random_way)
    );

    tag_array #(.N_SETS(N_SETS)) tag_array_i (
        .clk        (clk),
        .rst_aL     (rst_aL),
        .en         (accept | refill_wr),
        .we         (refill_wr),
        .way_mask   (victim ? 2'b10 : 2'b01),
        .index      (arr_index),
        .wr_tag     (addr_q[ADDR_WIDTH-1 -: N_TAG_BITS]),
        .way0_valid (way0_valid),
        .way0_tag   (way0_tag),
        .way1_valid (way1_valid),
        .way1_tag   (way1_tag)
    );

    data_array #(.N_SETS(N_SETS)) data_array_i (
        .clk       (clk),
        .en        (accept | store_wr | refill_wr),
        .we        (store_wr | refill_wr),
        .byte_mask (refill_wr ? (victim ? 16'hff00 : 16'h00ff)
                              : {sel1 ? store_mask : 8'h00, sel0 ? store_mask : 8'h00}),
        .index     (arr_index),
        .wr_block0 (arr_wr_block),
        .wr_block1 (arr_wr_block),
        .rd_block0 (rd_block0),
        .rd_block1 (rd_block1)
    );

    assign mem_req_valid = store_wr | (state == WRITE_REQ) | (state == REFILL_REQ);
    assign mem_req_type = (state == REFILL_REQ) ? READ : WRITE;
    assign mem_req_block_addr = addr_q[ADDR_WIDTH-1:N_OFFSET_BITS];
    assign mem_req_block_data = merged_block;  // array outputs hold while memory stalls

    always_ff @(posedge clk) begin
        if (!rst_aL) begin
            state <= IDLE;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) state <= COMPARE;
                end
                COMPARE: begin
                    if (!hit) begin
                        state <= REFILL_REQ;
                    end else if (type_q == READ || mem_req_ready) begin
                        state <= IDLE;
                        resp_valid <= 1'b1;
                    end else begin
                        state <= WRITE_REQ;  // write-through stalled
                    end
                end
                WRITE_REQ: begin
                    if (mem_req_ready) begin
                        state <= IDLE;
                        resp_valid <= 1'b1;
                    end
                end
                REFILL_REQ: begin
                    if (mem_req_ready) state <= REFILL_WAIT;
                end
                REFILL_WAIT: begin
                    if (mem_resp_valid) state <= IDLE;  // held request replays from idle
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            type_q <= req_type;
            width_q <= req_width;
            addr_q <= req_addr;
            wr_data_q <= req_wr_data;
        end
        if (state == COMPARE) begin
            victim <= victim_next;
            resp_rd_data <= hit_block[WORD_WIDTH*addr_q[N_OFFSET_BITS-1] +: WORD_WIDTH];
        end
    end

    // tags in one set stay distinct across refills
    a_one_way_hit: assert property (@(posedge clk) disable iff (!rst_aL)
        (state == COMPARE) |-> !(sel0 && sel1));

    a_aligned: assert property (@(posedge clk) disable iff (!rst_aL)
        accept |-> (req_width == BYTE) ||
                   (req_width == HALFWORD && !req_addr[0]) ||
                   (req_width == WORD && req_addr[1:0] == 2'b00));

    a_resp_in_refill: assert property (@(posedge clk) disable iff (!rst_aL)
        mem_resp_valid |-> (state == REFILL_WAIT));

endmodule

//--- design/data_array.sv
`timescale 1ns/1ps

module data_array
    import cache_pkg::*;
#(
    parameter int unsigned N_SETS = 16,
    localparam int unsigned N_INDEX_BITS = $clog2(N_SETS),
    localparam int unsigned N_BYTES = BLOCK_WIDTH / 8
) (
    input  logic                    clk,
    input  logic                    en,
    input  logic                    we,
    input  logic [2*N_BYTES-1:0]    byte_mask,  // way 1 in the upper half
    input  logic [N_INDEX_BITS-1:0] index,
    input  block_data_t             wr_block0,
    input  block_data_t             wr_block1,
    output block_data_t             rd_block0,
    output block_data_t             rd_block1
);
    block_data_t ways0 [N_SETS];
    block_data_t ways1 [N_SETS];

    // single port, a write cycle does no read
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                for (int b = 0; b < N_BYTES; b++) begin
                    if (byte_mask[b]) begin
                        ways0[index][8*b +: 8] <= wr_block0[8*b +: 8];
                    end
                    if (byte_mask[N_BYTES+b]) begin
                        ways1[index][8*b +: 8] <= wr_block1[8*b +: 8];
                    end
                end
            end else begin
                rd_block0 <= ways0[index];
                rd_block1 <= ways1[index];
            end
        end
    end

endmodule

//--- design/tag_array.sv
`timescale 1ns/1ps

module tag_array
    import cache_pkg::*;
#(
    parameter int unsigned N_SETS = 16,
    localparam int unsigned N_INDEX_BITS = $clog2(N_SETS),
    localparam int unsigned N_TAG_BITS = ADDR_WIDTH - N_OFFSET_BITS - N_INDEX_BITS
) (
    input  logic                    clk,
    input  logic                    rst_aL,
    input  logic                    en,
    input  logic                    we,
    input  logic [1:0]              way_mask,  // bit 1 is way 1
    input  logic [N_INDEX_BITS-1:0] index,
    input  logic [N_TAG_BITS-1:0]   wr_tag,
    output logic                    way0_valid,
    output logic [N_TAG_BITS-1:0]   way0_tag,
    output logic                    way1_valid,
    output logic [N_TAG_BITS-1:0]   way1_tag
);
    logic [N_TAG_BITS-1:0] tags0 [N_SETS];
    logic [N_TAG_BITS-1:0] tags1 [N_SETS];
    logic [N_SETS-1:0]     valid0;
    logic [N_SETS-1:0]     valid1;

    always_ff @(posedge clk) begin
        if (!rst_aL) begin
            valid0 <= '0;
            valid1 <= '0;
            way0_valid <= 1'b0;
            way1_valid <= 1'b0;
        end else if (en) begin
            if (we) begin
                if (way_mask[0]) valid0[index] <= 1'b1;
                if (way_mask[1]) valid1[index] <= 1'b1;
            end else begin
                way0_valid <= valid0[index];  // seen in the next cycle
                way1_valid <= valid1[index];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                if (way_mask[0]) tags0[index] <= wr_tag;
                if (way_mask[1]) tags1[index] <= wr_tag;
            end else begin
                way0_tag <= tags0[index];
                way1_tag <= tags1[index];
            end
        end
    end

    // a refill fills exactly one way
    a_one_way_written: assert property (@(posedge clk) disable iff (!rst_aL)
        (en && we) |-> (way_mask != 2'b11));

endmodule

//--- design/lfsr_8bit.sv
`timescale 1ns/1ps

module lfsr_8bit (
    input  logic clk,
    input  logic rst_aL,
    input  logic init,
    output logic out_bit
);
    localparam logic [7:0] SEED = 8'hb5;

    logic [7:0] lfsr_q;
    logic       phase;     // shift on every second clock
    logic       feedback;

    // taps 8,6,5,4 give the full 255-state sequence
    assign feedback = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

    always_ff @(posedge clk) begin
        if (!rst_aL || init) begin
            lfsr_q <= SEED;
            phase <= 1'b0;
        end else begin
            phase <= ~phase;
            if (phase) begin
                lfsr_q <= {lfsr_q[6:0], feedback};
            end
        end
    end

    assign out_bit = lfsr_q[0];  // victim way when the set is full

endmodule

//--- design/cache_pkg.sv
package cache_pkg;

    // address and data geometry
    parameter int unsigned ADDR_WIDTH = 16;    // byte address
    parameter int unsigned WORD_WIDTH = 32;
    parameter int unsigned BLOCK_WIDTH = 64;   // one cache line, 8 bytes
    parameter int unsigned N_OFFSET_BITS = 3;  // byte offset inside a block

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [BLOCK_WIDTH-1:0] block_data_t;

    // address with the byte offset stripped
    typedef logic [ADDR_WIDTH-N_OFFSET_BITS-1:0] block_addr_t;

    typedef enum logic {
        READ  = 1'b0,
        WRITE = 1'b1
    } req_type_t;

    typedef enum logic [1:0] {
        BYTE     = 2'd0,
        HALFWORD = 2'd1,
        WORD     = 2'd2
    } req_width_t;

endpackage
